//--- rtl/tilemapPkg.sv
package tilemapPkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes

	// two scrolling layers, A and B
	localparam int numLayers = 2;
	// cpu and tile ram data width
	localparam int dataW = 8;
	// scroll widths, 512 wide by 256 high map
	localparam int hScrollW = 9;
	localparam int vScrollW = 8;
	localparam int priW = 3;
	// layer, tile row 5, tile column 6, byte select
	localparam int ramAddrW = 13;
	localparam int tileCodeW = 10;
	// tile code 10, fine row 3, nibble 1
	localparam int romAddrW = 14;
	// register offset, bit 2 picks the layer
	localparam int regAddrW = 4;
	// raster counter, bit 0 is the layer slot
	localparam int hCountW = 10;

	////////////////////////////////////////////////////////////////////////////
	// bus and video types

	// apb request, driven by the cpu side
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [ramAddrW-1:0] paddr;
		logic [dataW-1:0] pwdata;
	} apbReq_t;

	// apb response back to the cpu
	typedef struct packed {
		logic pready;
		logic pslverr;
		logic [dataW-1:0] prdata;
	} apbRsp_t;

	// per layer settings
	typedef struct packed {
		logic [hScrollW-1:0] hScroll;
		logic [vScrollW-1:0] vScroll;
		logic [priW-1:0] pri;
	} layerCfg_t;

	// video side tile ram read
	typedef struct packed {
		logic [ramAddrW-1:0] ramAddr;
		logic layer;
	} ramRead_t;

	// graphics rom fetch request
	typedef struct packed {
		logic valid;
		logic layer;
		logic [romAddrW-1:0] romAddr;
	} gfxReq_t;

endpackage

//--- rtl/scrollRegs.sv
module scrollRegs (
	input logic CLK_6M,
	input logic arstN,
	input tilemapPkg::apbReq_t regApb,
	output tilemapPkg::apbRsp_t regRsp,
	output tilemapPkg::layerCfg_t layerCfg [tilemapPkg::numLayers]
);

	////////////////////////////////////////////////////////////////////////////
	// offset decode

	logic [tilemapPkg::regAddrW-1:0] offset;
	logic regLayer;
	logic [1:0] field;
	logic access;
	logic hit;
	tilemapPkg::layerCfg_t selCfg;

	assign offset = regApb.paddr[tilemapPkg::regAddrW-1:0];
	// bit 2 picks layer, bits 1..0 the field
	assign regLayer = offset[2];
	assign field = offset[1:0];
	assign access = regApb.psel & regApb.penable;
	// offsets 3, 7 and 8 up are holes
	assign hit = ~offset[3] & (field != 2'd3);
	assign selCfg = layerCfg[regLayer];

	////////////////////////////////////////////////////////////////////////////
	// register writes

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < tilemapPkg::numLayers; i++) begin
				layerCfg[i] <= '0;
			end
		end else if (access && regApb.pwrite && hit) begin
			case (field)
				// low 8 bits of h scroll
				2'd0: layerCfg[regLayer].hScroll[tilemapPkg::dataW-1:0] <= regApb.pwdata;
				// ninth h scroll bit plus priority
				2'd1: begin
					layerCfg[regLayer].hScroll[tilemapPkg::hScrollW-1] <= regApb.pwdata[0];
					layerCfg[regLayer].pri <= regApb.pwdata[tilemapPkg::priW:1];
				end
				// v scroll, whole byte
				default: layerCfg[regLayer].vScroll <= regApb.pwdata;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read back and response

	always_comb begin
		regRsp = '0;
		// no wait states
		regRsp.pready = access;
		regRsp.pslverr = access & ~hit;
		case (field)
			2'd0: regRsp.prdata = selCfg.hScroll[tilemapPkg::dataW-1:0];
			2'd1: begin
				regRsp.prdata[0] = selCfg.hScroll[tilemapPkg::hScrollW-1];
				regRsp.prdata[tilemapPkg::priW:1] = selCfg.pri;
			end
			2'd2: regRsp.prdata = selCfg.vScroll;
			// hole reads as zero
			default: regRsp.prdata = '0;
		endcase
		// upper offsets are holes too
		if (!hit) begin
			regRsp.prdata = '0;
		end
	end

endmodule

//--- rtl/tileRam.sv
module tileRam (
	input logic CLK_6M,
	input tilemapPkg::apbReq_t ramApb,
	output tilemapPkg::apbRsp_t ramRsp,
	input tilemapPkg::ramRead_t ramRead,
	output logic [tilemapPkg::dataW-1:0] ramData
);

	// 8 KB, two layers of 64x32 tiles, two bytes each
	logic [tilemapPkg::dataW-1:0] mem [1 << tilemapPkg::ramAddrW];

	logic access;
	logic [tilemapPkg::ramAddrW-1:0] videoAddr;

	assign access = ramApb.psel & ramApb.penable;

	// layer from the request picks the bank
	assign videoAddr = {ramRead.layer, ramRead.ramAddr[tilemapPkg::ramAddrW-2:0]};

	////////////////////////////////////////////////////////////////////////////
	// cpu port

	// write lands at the edge closing the access phase
	always_ff @(posedge CLK_6M) begin
		if (access && ramApb.pwrite) begin
			mem[ramApb.paddr] <= ramApb.pwdata;
		end
	end

	// single cycle access, never errors
	always_comb begin
		ramRsp.pready = access;
		ramRsp.pslverr = 1'b0;
		ramRsp.prdata = mem[ramApb.paddr];
	end

	////////////////////////////////////////////////////////////////////////////
	// video port

	// one clock read latency
	// same address as a cpu write sees the old byte
	always_ff @(posedge CLK_6M) begin
		ramData <= mem[videoAddr];
	end

endmodule

//--- rtl/tileFetcher.sv
module tileFetcher (
	input logic CLK_6M,
	input logic arstN,
	input logic hSyncN,
	input logic vSyncN,
	input tilemapPkg::layerCfg_t layerCfg [tilemapPkg::numLayers],
	output tilemapPkg::ramRead_t ramRead,
	input logic [tilemapPkg::dataW-1:0] ramData,
	output tilemapPkg::gfxReq_t gfxReq,
	output logic haCommit,
	output logic hbCommit
);

	////////////////////////////////////////////////////////////////////////////
	// sync edges and screen counters

	logic hSyncPrev;
	logic vSyncPrev;
	logic hFall;
	logic vFall;
	logic [tilemapPkg::hCountW-1:0] hCount;
	logic [tilemapPkg::vScrollW-1:0] vCount;

	assign hFall = ~hSyncN & hSyncPrev;
	assign vFall = ~vSyncN & vSyncPrev;

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			// syncs idle high
			hSyncPrev <= 1'b1;
			vSyncPrev <= 1'b1;
			hCount <= '0;
			vCount <= '0;
		end else begin
			hSyncPrev <= hSyncN;
			vSyncPrev <= vSyncN;
			// new line
			hCount <= hFall ? '0 : hCount + 1'b1;
			// new frame wins over new line
			if (vFall) begin
				vCount <= '0;
			end else if (hFall) begin
				vCount <= vCount + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// per slot scroll and tile ram address

	logic slotLayer;
	tilemapPkg::layerCfg_t cfg;
	logic [tilemapPkg::hScrollW-1:0] xPos;
	logic [tilemapPkg::vScrollW-1:0] yPos;

	// even clocks layer 0, odd clocks layer 1
	assign slotLayer = hCount[0];
	assign cfg = layerCfg[slotLayer];
	// each layer moves one pixel every two clocks
	assign xPos = hCount[tilemapPkg::hCountW-1:1] + cfg.hScroll;
	assign yPos = vCount + cfg.vScroll;

	// layer, tile row, tile column, byte select
	assign ramRead.ramAddr = {slotLayer, yPos[7:3], xPos[8:3], xPos[2]};
	assign ramRead.layer = slotLayer;

	////////////////////////////////////////////////////////////////////////////
	// stage 1, meets the returning ram byte

	logic s1Valid;
	logic s1Layer;
	logic [2:0] s1FineRow;
	logic s1Nibble;
	logic s1ByteSel;
	logic [tilemapPkg::dataW-1:0] codeLow [tilemapPkg::numLayers];
	logic [tilemapPkg::tileCodeW-1:0] codeCommit [tilemapPkg::numLayers];
	logic [tilemapPkg::tileCodeW-1:0] nextCode;

	// high byte completes the code, otherwise keep the last committed one
	assign nextCode = s1ByteSel ?
		{ramData[tilemapPkg::tileCodeW-tilemapPkg::dataW-1:0], codeLow[s1Layer]} :
		codeCommit[s1Layer];

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			s1Valid <= 1'b0;
			s1Layer <= 1'b0;
			s1FineRow <= '0;
			s1Nibble <= 1'b0;
			s1ByteSel <= 1'b0;
			haCommit <= 1'b0;
			hbCommit <= 1'b0;
		end else begin
			// pipeline full after the first clock
			s1Valid <= 1'b1;
			s1Layer <= slotLayer;
			s1FineRow <= yPos[2:0];
			s1Nibble <= xPos[1];
			s1ByteSel <= xPos[2];
			// pixel commit per layer at x phase 2
			haCommit <= ~slotLayer & (xPos[2:0] == 3'd2);
			hbCommit <= slotLayer & (xPos[2:0] == 3'd2);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// code assembly and rom request

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < tilemapPkg::numLayers; i++) begin
				codeLow[i] <= '0;
				codeCommit[i] <= '0;
			end
			gfxReq <= '0;
		end else begin
			if (s1ByteSel) begin
				codeCommit[s1Layer] <= nextCode;
			end else begin
				codeLow[s1Layer] <= ramData;
			end
			// code, fine row, nibble
			gfxReq.valid <= s1Valid;
			gfxReq.layer <= s1Layer;
			gfxReq.romAddr <= {nextCode, s1FineRow, s1Nibble};
		end
	end

endmodule

//--- rtl/tilemapGen.sv
module tilemapGen (
	input logic CLK_6M,
	input logic arstN,
	input tilemapPkg::apbReq_t regApb,
	output tilemapPkg::apbRsp_t regRsp,
	input tilemapPkg::apbReq_t ramApb,
	output tilemapPkg::apbRsp_t ramRsp,
	input logic hSyncN,
	input logic vSyncN,
	output tilemapPkg::gfxReq_t gfxReq,
	output logic haCommit,
	output logic hbCommit
);

	// settings from cpu to fetch engine
	tilemapPkg::layerCfg_t layerCfg [tilemapPkg::numLayers];
	// video port of the tile ram
	tilemapPkg::ramRead_t ramRead;
	logic [tilemapPkg::dataW-1:0] ramData;

	////////////////////////////////////////////////////////////////////////////
	// scroll and priority registers

	scrollRegs i_scrollRegs (
		.CLK_6M(CLK_6M),
		.arstN(arstN),
		.regApb(regApb),
		.regRsp(regRsp),
		.layerCfg(layerCfg)
	);

	// tile map storage
	tileRam i_tileRam (
		.CLK_6M(CLK_6M),
		.ramApb(ramApb),
		.ramRsp(ramRsp),
		.ramRead(ramRead),
		.ramData(ramData)
	);

	// raster side address generator
	tileFetcher i_tileFetcher (
		.CLK_6M(CLK_6M),
		.arstN(arstN),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.layerCfg(layerCfg),
		.ramRead(ramRead),
		.ramData(ramData),
		.gfxReq(gfxReq),
		.haCommit(haCommit),
		.hbCommit(hbCommit)
	);

endmodule

//--- verif/tilemapGenChk.sv
module tilemapGenChk (
	input logic CLK_6M,
	input logic arstN,
	input tilemapPkg::apbReq_t regApb,
	input tilemapPkg::apbRsp_t regRsp,
	input tilemapPkg::apbReq_t ramApb,
	input tilemapPkg::apbRsp_t ramRsp,
	input logic hSyncN,
	input logic vSyncN,
	input tilemapPkg::gfxReq_t gfxReq,
	input logic haCommit,
	input logic hbCommit,
	input tilemapPkg::ramRead_t ramRead
);
	timeunit 1ns;
	timeprecision 100ps;

	// failed assertions, read by the testbench
	int errCount = 0;
	// readback image of the register bank, holes stay zero
	logic [7:0] regShadow [16];
	logic [7:0] ramShadow [8192];
	logic written [8192] = '{default: 1'b0};
	int writtenCnt = 0;
	logic regAcc;
	logic ramAcc;
	logic regHole;
	logic [3:0] off;
	logic hPrev;
	logic vPrev;
	logic [9:0] hCnt;
	logic [7:0] vCnt;
	logic lay;
	logic [8:0] x;
	logic [7:0] y;
	logic [12:0] expAddr;
	logic [7:0] lowByte [2];
	logic lowSeen [2];
	logic d1Chk;
	logic d2Chk;
	logic d1Lay;
	logic d2Lay;
	logic d1A;
	logic d1B;
	logic [13:0] d1Rom;
	logic [13:0] d2Rom;

	assign regAcc = regApb.psel & regApb.penable;
	assign ramAcc = ramApb.psel & ramApb.penable;
	assign off = regApb.paddr[3:0];
	assign regHole = off[3] | (off[1:0] == 2'd3);
	// screen position of the slot plus the shadowed scroll
	assign lay = hCnt[0];
	assign x = hCnt[9:1] + {regShadow[{1'b0, lay, 2'd1}][0], regShadow[{1'b0, lay, 2'd0}]};
	assign y = vCnt + regShadow[{1'b0, lay, 2'd2}];
	assign expAddr = {lay, y[7:3], x[8:3], x[2]};

	////////////////////////////////////////////////////////////////////////////
	// shadows and expected pipeline

	// tile ram image, no reset like the array itself
	always_ff @(posedge CLK_6M) begin
		if (ramAcc && ramApb.pwrite) begin
			ramShadow[ramApb.paddr] <= ramApb.pwdata;
			if (!written[ramApb.paddr]) begin
				written[ramApb.paddr] <= 1'b1;
				writtenCnt <= writtenCnt + 1;
			end
		end
	end

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 16; i++) begin
				regShadow[i] <= '0;
			end
			hPrev <= 1'b1;
			vPrev <= 1'b1;
			hCnt <= '0;
			vCnt <= '0;
			lowSeen[0] <= 1'b0;
			lowSeen[1] <= 1'b0;
			{d1Chk, d2Chk, d1Lay, d2Lay, d1A, d1B} <= '0;
			d1Rom <= '0;
			d2Rom <= '0;
		end else begin
			// offset 1 keeps ninth h bit and pri only
			if (regAcc && regApb.pwrite && !regHole) begin
				regShadow[off] <= (off[1:0] == 2'd1) ? (regApb.pwdata & 8'h0f) : regApb.pwdata;
			end
			// counters restart at the observed sync edges
			hPrev <= hSyncN;
			vPrev <= vSyncN;
			hCnt <= (hPrev && !hSyncN) ? '0 : hCnt + 1'b1;
			if (vPrev && !vSyncN) begin
				vCnt <= '0;
			end else if (hPrev && !hSyncN) begin
				vCnt <= vCnt + 1'b1;
			end
			// low byte of the layer, trusted once the whole ram is written
			if (!x[2]) begin
				lowByte[lay] <= ramShadow[expAddr];
				lowSeen[lay] <= (writtenCnt == 8192);
			end
			d1Chk <= x[2] && lowSeen[lay] && (writtenCnt == 8192);
			d1Lay <= lay;
			d1Rom <= {ramShadow[expAddr][1:0], lowByte[lay], y[2:0], x[1]};
			d1A <= !lay && (x[2:0] == 3'd2);
			d1B <= lay && (x[2:0] == 3'd2);
			d2Chk <= d1Chk;
			d2Lay <= d1Lay;
			d2Rom <= d1Rom;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// assertions

	// outputs quiet in reset and on the first clock after release
	aResetQuiet: assert property (@(posedge CLK_6M)
		(!arstN || $rose(arstN)) |-> !gfxReq.valid && !haCommit && !hbCommit)
		else begin
			errCount++;
			$error("gfxReq.valid or a commit strobe is high during or right after reset");
		end

	// pipeline filled two clocks after release
	aValidRise: assert property (@(posedge CLK_6M) $rose(arstN) |-> ##2 gfxReq.valid)
		else begin
			errCount++;
			$error("gfxReq.valid did not rise within two clocks of reset release");
		end

	aPready: assert property (@(posedge CLK_6M) disable iff (!arstN)
		regRsp.pready == regAcc && ramRsp.pready == ramAcc)
		else begin
			errCount++;
			$error("MISMATCH {regRsp.pready, ramRsp.pready} exp %h got %h",
				$sampled({regAcc, ramAcc}), $sampled({regRsp.pready, ramRsp.pready}));
		end

	aSlvErr: assert property (@(posedge CLK_6M) disable iff (!arstN)
		regRsp.pslverr == (regAcc && regHole) && !ramRsp.pslverr)
		else begin
			errCount++;
			$error("MISMATCH {regRsp.pslverr, ramRsp.pslverr} exp %h got %h",
				$sampled({regAcc && regHole, 1'b0}),
				$sampled({regRsp.pslverr, ramRsp.pslverr}));
		end

	aRegRead: assert property (@(posedge CLK_6M) disable iff (!arstN)
		regAcc && !regApb.pwrite |-> regRsp.prdata == regShadow[off])
		else begin
			errCount++;
			$error("MISMATCH regRsp.prdata exp %h got %h", $sampled(regShadow[off]),
				$sampled(regRsp.prdata));
		end

	aRamRead: assert property (@(posedge CLK_6M) disable iff (!arstN)
		ramAcc && !ramApb.pwrite && written[ramApb.paddr] |->
		ramRsp.prdata == ramShadow[ramApb.paddr])
		else begin
			errCount++;
			$error("MISMATCH ramRsp.prdata exp %h got %h",
				$sampled(ramShadow[ramApb.paddr]), $sampled(ramRsp.prdata));
		end

	aRamAddr: assert property (@(posedge CLK_6M) disable iff (!arstN)
		ramRead.ramAddr == expAddr && ramRead.layer == lay)
		else begin
			errCount++;
			$error("MISMATCH ramRead exp %h got %h", $sampled({expAddr, lay}),
				$sampled(ramRead));
		end

	// high byte fetch two clocks back
	aGfx: assert property (@(posedge CLK_6M) disable iff (!arstN)
		d2Chk |-> gfxReq.valid && gfxReq.layer == d2Lay && gfxReq.romAddr == d2Rom)
		else begin
			errCount++;
			$error("MISMATCH gfxReq exp %h got %h", $sampled({1'b1, d2Lay, d2Rom}),
				$sampled(gfxReq));
		end

	aCommit: assert property (@(posedge CLK_6M) disable iff (!arstN)
		haCommit == d1A && hbCommit == d1B)
		else begin
			errCount++;
			$error("MISMATCH {haCommit, hbCommit} exp %h got %h", $sampled({d1A, d1B}),
				$sampled({haCommit, hbCommit}));
		end

endmodule

//--- verif/tilemapGenTb.sv
module tilemapGenTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int waitLimit = 64;

	logic CLK_6M = 1'b0;
	logic arstN;
	tilemapPkg::apbReq_t regApb;
	tilemapPkg::apbReq_t ramApb;
	tilemapPkg::apbRsp_t regRsp;
	tilemapPkg::apbRsp_t ramRsp;
	logic hSyncN;
	logic vSyncN;
	tilemapPkg::gfxReq_t gfxReq;
	logic haCommit;
	logic hbCommit;
	logic [31:0] lcgState;
	int testsRun = 0;
	int testsFailed = 0;
	int timeouts = 0;
	int errStart;
	int toStart;

	tilemapGen i_dut (.*);

	bind tilemapGen tilemapGenChk i_chk (.*);

	// 4 ns period
	always #2 CLK_6M = ~CLK_6M;

	////////////////////////////////////////////////////////////////////////////
	// helpers

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// even byte low index bits, odd byte index bits 8 and 9
	function automatic logic [7:0] fillByte(input logic [12:0] addr);
		logic [10:0] idx;
		idx = addr[11:1];
		if (!addr[0]) begin
			return idx[7:0];
		end
		return {6'b0, idx[9], idx[8] ^ addr[12]};
	endfunction

	// one apb transfer, setup then access, called on a falling edge
	task automatic apbXfer(input bit toRegs, input bit write, input logic [12:0] addr,
			input logic [7:0] data);
		tilemapPkg::apbReq_t req;
		int n;
		req = '0;
		req.psel = 1'b1;
		req.pwrite = write;
		req.paddr = addr;
		req.pwdata = data;
		if (toRegs) begin
			regApb = req;
		end else begin
			ramApb = req;
		end
		@(negedge CLK_6M);
		req.penable = 1'b1;
		if (toRegs) begin
			regApb = req;
		end else begin
			ramApb = req;
		end
		n = 0;
		#1;
		while (!(toRegs ? regRsp.pready : ramRsp.pready)) begin
			if (n == waitLimit) begin
				$display("timeout: pready never came on the %s port", toRegs ? "reg" : "ram");
				timeouts++;
				break;
			end
			@(negedge CLK_6M);
			#1;
			n++;
		end
		@(negedge CLK_6M);
		if (toRegs) begin
			regApb = '0;
		end else begin
			ramApb = '0;
		end
	endtask

	task automatic syncPulse(input bit vertical);
		if (vertical) begin
			vSyncN = 1'b0;
		end else begin
			hSyncN = 1'b0;
		end
		repeat (3) @(negedge CLK_6M);
		hSyncN = 1'b1;
		vSyncN = 1'b1;
	endtask

	task automatic waitCommit(input bit layerB);
		int n;
		n = 0;
		while (!(layerB ? hbCommit : haCommit)) begin
			if (n == waitLimit) begin
				$display("timeout: commit strobe of layer %0d never rose", layerB);
				timeouts++;
				break;
			end
			@(negedge CLK_6M);
			n++;
		end
	endtask

	task automatic startTest();
		errStart = i_dut.i_chk.errCount;
		toStart = timeouts;
	endtask

	task automatic endTest(input string name);
		int fails;
		fails = i_dut.i_chk.errCount - errStart + timeouts - toStart;
		testsRun++;
		if (fails != 0) begin
			testsFailed++;
			$display("test %0d %s: FAILED, %0d problems", testsRun, name, fails);
		end else begin
			$display("test %0d %s: ok", testsRun, name);
		end
	endtask

	// both layers from lcg, ninth h bit forced when asked
	task automatic setScroll(input bit forceHigh);
		logic [31:0] r;
		for (int l = 0; l < 2; l++) begin
			r = lcgNext();
			apbXfer(1'b1, 1'b1, {10'd0, l[0], 2'd0}, r[15:8]);
			apbXfer(1'b1, 1'b1, {10'd0, l[0], 2'd1}, {4'd0, r[27:25], r[24] | forceHigh});
			apbXfer(1'b1, 1'b1, {10'd0, l[0], 2'd2}, r[23:16]);
		end
	endtask

	// run limit
	initial begin
		#5ms;
		$display("simulation ran past its time limit");
		$display("*** TEST FAILED ***");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	initial begin
		int n;
		logic [31:0] r;
		arstN = 1'b0;
		regApb = '0;
		ramApb = '0;
		hSyncN = 1'b1;
		vSyncN = 1'b1;
		lcgState = 32'h111b_328b;
		repeat (2) @(negedge CLK_6M);

		// reset state, valid after release
		startTest();
		arstN = 1'b1;
		n = 0;
		while (!gfxReq.valid) begin
			if (n == waitLimit) begin
				$display("timeout: gfxReq.valid never rose after reset");
				timeouts++;
				break;
			end
			@(negedge CLK_6M);
			n++;
		end
		endTest("reset state");

		// every offset written, holes included, then read back
		startTest();
		for (int a = 0; a < 16; a++) begin
			r = lcgNext();
			apbXfer(1'b1, 1'b1, 13'(a), r[23:16]);
		end
		for (int a = 0; a < 16; a++) begin
			apbXfer(1'b1, 1'b0, 13'(a), 8'h00);
		end
		endTest("register bank");

		// fill the whole map
		startTest();
		for (int a = 0; a < 8192; a++) begin
			apbXfer(1'b0, 1'b1, 13'(a), fillByte(13'(a)));
		end
		// read every byte back
		for (int a = 0; a < 8192; a++) begin
			apbXfer(1'b0, 1'b0, 13'(a), 8'h00);
		end
		// random re-reads
		for (int k = 0; k < 64; k++) begin
			r = lcgNext();
			apbXfer(1'b0, 1'b0, r[28:16], 8'h00);
		end
		endTest("tile ram port");

		startTest();
		for (int s = 0; s < 4; s++) begin
			setScroll(s == 0);
			repeat (300) @(negedge CLK_6M);
		end
		endTest("fetch path");

		// vsync on the third line
		startTest();
		for (int k = 0; k < 6; k++) begin
			r = lcgNext();
			if (k == 2) begin
				syncPulse(1'b1);
			end
			syncPulse(1'b0);
			if (k == 4) begin
				setScroll(1'b0);
			end
			waitCommit(1'b0);
			waitCommit(1'b1);
			repeat (40 + int'(r[21:16])) @(negedge CLK_6M);
		end
		endTest("scroll and sync");

		$display("%0d tests, %0d failed, %0d assertion failures, %0d timeouts",
			testsRun, testsFailed, i_dut.i_chk.errCount, timeouts);
		if (testsFailed == 0 && i_dut.i_chk.errCount == 0 && timeouts == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- project.f
rtl/tilemapPkg.sv
rtl/scrollRegs.sv
rtl/tileRam.sv
rtl/tileFetcher.sv
rtl/tilemapGen.sv
verif/tilemapGenChk.sv
verif/tilemapGenTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tilemapGenTb -f project.f

# keep running past assertion errors so the testbench reports the result
out=$(./obj_dir/VtilemapGenTb +verilator+error+limit+100000 || true)
echo "$out"

grep -qF '*** TEST PASSED ***' <<< "$out"
